// ==== hdl/ecc_sram_pkg.sv ====
// Shared definitions of the ECC SRAM subsystem
// Widths, bank count, AXI register map and the word typedefs
// SECDED encode and decode over a 39-bit Hamming plus overall parity code
package ecc_sram_pkg;

  localparam int unsigned NumBanks      = 2;
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);
  localparam int unsigned WordsPerBank  = 256;
  localparam int unsigned AddrWidth     = 8;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned EccWidth      = 7;
  localparam int unsigned CodeWidth     = DataWidth + EccWidth;
  localparam int unsigned CountWidth    = 32;
  localparam int unsigned AxilAddrWidth = 8;

  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [CodeWidth-1:0]     code_t;
  typedef logic [EccWidth-1:0]      ecc_t;
  typedef logic [AddrWidth-1:0]     word_addr_t;
  typedef logic [CountWidth-1:0]    count_t;
  typedef logic [AxilAddrWidth-1:0] axil_addr_t;
  typedef logic [BankSelWidth-1:0]  bank_sel_t;

  // Register map, bank b of a per-bank register sits at base + 4*b
  localparam axil_addr_t RegScrubInterval = 8'h00;
  localparam axil_addr_t RegMismatchBase  = 8'h10;
  localparam axil_addr_t RegScrubFixBase  = 8'h20;
  localparam axil_addr_t RegUncorrBase    = 8'h30;
  localparam axil_addr_t RegInjDataBase   = 8'h40;
  localparam axil_addr_t RegInjEccBase    = 8'h50;

  // Hamming position of data bit idx
  // Data bits fill positions 3 to 38 and skip the power-of-two check positions
  function automatic logic [EccWidth-2:0] data_pos(input int unsigned idx);
    logic [EccWidth-2:0] pos;
    int unsigned         cnt;
    pos = '0;
    cnt = 0;
    for (int unsigned p = 3; p < CodeWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == idx) begin
          pos = (EccWidth-1)'(p);
        end
        cnt++;
      end
    end
    return pos;
  endfunction

  // Each check bit covers the positions that have its bit set, so XOR of all set positions
  function automatic logic [EccWidth-2:0] hamming_bits(input data_t data);
    logic [EccWidth-2:0] chk;
    chk = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (data[i]) begin
        chk ^= data_pos(i);
      end
    end
    return chk;
  endfunction

  // Stored word is {overall parity, Hamming bits, data}
  function automatic code_t secded_encode(input data_t data);
    logic [EccWidth-2:0] chk;
    chk = hamming_bits(data);
    return {^{chk, data}, chk, data};
  endfunction

  // Odd overall parity means one flipped bit, the syndrome then names its position
  // Even parity with a nonzero syndrome means two flipped bits, data passes through
  function automatic data_t secded_decode(input code_t code, output logic single_err,
                                          output logic double_err);
    logic [EccWidth-2:0] syn;
    logic                par;
    data_t               data;
    data       = code[DataWidth-1:0];
    syn        = hamming_bits(data) ^ code[DataWidth +: EccWidth-1];
    par        = ^code;
    single_err = par;
    double_err = !par && (syn != '0);
    if (par) begin
      for (int unsigned i = 0; i < DataWidth; i++) begin
        if (data_pos(i) == syn) begin
          data[i] = ~data[i];
        end
      end
    end
    return data;
  endfunction

endpackage

// ==== hdl/ecc_axil_regs.sv ====
`timescale 1ns/1ps
// AXI4-Lite register file of the ECC SRAM subsystem
// Holds the scrub interval and the per-bank fault injection masks
// Reads the per-bank event counters and pulses their clears
module ecc_axil_regs (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  ecc_sram_pkg::axil_addr_t                           s_axil_awaddr_i,
  input  logic                                               s_axil_awvalid_i,
  output logic                                               s_axil_awready_o,
  input  ecc_sram_pkg::data_t                                s_axil_wdata_i,
  input  logic                                               s_axil_wvalid_i,
  output logic                                               s_axil_wready_o,
  output logic                                               s_axil_bvalid_o,
  input  logic                                               s_axil_bready_i,
  output logic [1:0]                                         s_axil_bresp_o,
  input  ecc_sram_pkg::axil_addr_t                           s_axil_araddr_i,
  input  logic                                               s_axil_arvalid_i,
  output logic                                               s_axil_arready_o,
  output ecc_sram_pkg::data_t                                s_axil_rdata_o,
  output logic                                               s_axil_rvalid_o,
  input  logic                                               s_axil_rready_i,
  output logic [1:0]                                         s_axil_rresp_o,
  output ecc_sram_pkg::count_t                               scrub_interval_o,
  output logic [ecc_sram_pkg::NumBanks-1:0]                  count_clear_o,
  output ecc_sram_pkg::data_t  [ecc_sram_pkg::NumBanks-1:0]  inj_data_mask_o,
  output ecc_sram_pkg::ecc_t   [ecc_sram_pkg::NumBanks-1:0]  inj_ecc_mask_o,
  input  ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  mismatch_count_i,
  input  ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  scrub_fix_count_i,
  input  ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  uncorr_count_i
);

  typedef enum logic [1:0] {WrIdle, WrHaveAddr, WrHaveData, WrResp} wr_state_e;

  wr_state_e                wr_state_q, wr_state_d;
  ecc_sram_pkg::axil_addr_t wr_addr_q, wr_addr;
  ecc_sram_pkg::data_t      wr_data_q, wr_data, rd_mux;
  logic                     aw_hs, w_hs, ar_hs, wr_en;

  // True when addr hits the register of bank b in the block starting at base
  function automatic logic bank_hit(input ecc_sram_pkg::axil_addr_t addr,
                                    input ecc_sram_pkg::axil_addr_t base, input int unsigned b);
    return addr == ecc_sram_pkg::axil_addr_t'(base + 4 * b);
  endfunction

  // Each address channel is open while its half of the write is still missing
  assign s_axil_awready_o = (wr_state_q == WrIdle) || (wr_state_q == WrHaveData);
  assign s_axil_wready_o  = (wr_state_q == WrIdle) || (wr_state_q == WrHaveAddr);
  assign s_axil_bvalid_o  = (wr_state_q == WrResp);
  assign s_axil_bresp_o   = 2'b00;
  assign s_axil_rresp_o   = 2'b00;
  assign aw_hs = s_axil_awvalid_i && s_axil_awready_o;
  assign w_hs  = s_axil_wvalid_i && s_axil_wready_o;
  assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;

  // The half that arrived first comes from its holding register
  assign wr_addr = (wr_state_q == WrHaveAddr) ? wr_addr_q : s_axil_awaddr_i;
  assign wr_data = (wr_state_q == WrHaveData) ? wr_data_q : s_axil_wdata_i;

  always_comb begin
    wr_state_d = wr_state_q;
    wr_en      = 1'b0;
    unique case (wr_state_q)
      WrIdle: begin
        if (aw_hs && w_hs) begin
          wr_en      = 1'b1;
          wr_state_d = WrResp;
        end else if (aw_hs) begin
          wr_state_d = WrHaveAddr;
        end else if (w_hs) begin
          wr_state_d = WrHaveData;
        end
      end
      WrHaveAddr, WrHaveData: begin
        if (aw_hs || w_hs) begin
          wr_en      = 1'b1;
          wr_state_d = WrResp;
        end
      end
      default: begin
        if (s_axil_bready_i) begin
          wr_state_d = WrIdle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q       <= WrIdle;
      scrub_interval_o <= '0;
      inj_data_mask_o  <= '0;
      inj_ecc_mask_o   <= '0;
      count_clear_o    <= '0;
    end else begin
      wr_state_q    <= wr_state_d;
      count_clear_o <= '0;
      if (wr_en) begin
        if (wr_addr == ecc_sram_pkg::RegScrubInterval) begin
          scrub_interval_o <= wr_data;
        end
        for (int unsigned b = 0; b < ecc_sram_pkg::NumBanks; b++) begin
          if (bank_hit(wr_addr, ecc_sram_pkg::RegInjDataBase, b)) begin
            inj_data_mask_o[b] <= wr_data;
          end
          if (bank_hit(wr_addr, ecc_sram_pkg::RegInjEccBase, b)) begin
            inj_ecc_mask_o[b] <= wr_data[ecc_sram_pkg::EccWidth-1:0];
          end
          // Any of the three counter offsets clears the whole bank set
          if (bank_hit(wr_addr, ecc_sram_pkg::RegMismatchBase, b) ||
              bank_hit(wr_addr, ecc_sram_pkg::RegScrubFixBase, b) ||
              bank_hit(wr_addr, ecc_sram_pkg::RegUncorrBase, b)) begin
            count_clear_o[b] <= 1'b1;
          end
        end
      end
    end
  end

  // Read data mux, unmapped offsets return 0
  always_comb begin
    rd_mux = '0;
    if (s_axil_araddr_i == ecc_sram_pkg::RegScrubInterval) begin
      rd_mux = scrub_interval_o;
    end
    for (int unsigned b = 0; b < ecc_sram_pkg::NumBanks; b++) begin
      if (bank_hit(s_axil_araddr_i, ecc_sram_pkg::RegMismatchBase, b)) begin
        rd_mux = mismatch_count_i[b];
      end
      if (bank_hit(s_axil_araddr_i, ecc_sram_pkg::RegScrubFixBase, b)) begin
        rd_mux = scrub_fix_count_i[b];
      end
      if (bank_hit(s_axil_araddr_i, ecc_sram_pkg::RegUncorrBase, b)) begin
        rd_mux = uncorr_count_i[b];
      end
      if (bank_hit(s_axil_araddr_i, ecc_sram_pkg::RegInjDataBase, b)) begin
        rd_mux = inj_data_mask_o[b];
      end
      if (bank_hit(s_axil_araddr_i, ecc_sram_pkg::RegInjEccBase, b)) begin
        rd_mux = ecc_sram_pkg::data_t'(inj_ecc_mask_o[b]);
      end
    end
  end

  // One read in flight, a new AR waits until the response is taken
  assign s_axil_arready_o = !s_axil_rvalid_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s_axil_rvalid_o <= 1'b0;
    end else if (ar_hs) begin
      s_axil_rvalid_o <= 1'b1;
    end else if (s_axil_rready_i) begin
      s_axil_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_addr_q <= s_axil_awaddr_i;
    end
    if (w_hs) begin
      wr_data_q <= s_axil_wdata_i;
    end
    if (ar_hs) begin
      s_axil_rdata_o <= rd_mux;
    end
  end

  // Responses are held until the master takes them
  bvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);
  rvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o);

endmodule

// ==== hdl/ecc_fault_monitor.sv ====
`timescale 1ns/1ps
// Fault monitor of the ECC SRAM subsystem
// Per-bank ECC event counters and scrub interval timers
module ecc_fault_monitor (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  ecc_sram_pkg::count_t                               scrub_interval_i,
  input  logic [ecc_sram_pkg::NumBanks-1:0]                  count_clear_i,
  input  logic [ecc_sram_pkg::NumBanks-1:0]                  read_fix_i,
  input  logic [ecc_sram_pkg::NumBanks-1:0]                  scrub_fix_i,
  input  logic [ecc_sram_pkg::NumBanks-1:0]                  scrub_uncorr_i,
  output ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  mismatch_count_o,
  output ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  scrub_fix_count_o,
  output ecc_sram_pkg::count_t [ecc_sram_pkg::NumBanks-1:0]  uncorr_count_o,
  output logic [ecc_sram_pkg::NumBanks-1:0]                  scrub_trigger_o
);

  // A zero interval switches the scrub timers off
  logic interval_on;

  assign interval_on = (scrub_interval_i != '0);

  for (genvar b = 0; b < ecc_sram_pkg::NumBanks; b++) begin : gen_bank
    ecc_sram_pkg::count_t mismatch_q, fix_q, uncorr_q, timer_q;

    // Counters step on the edge after the event and a clear wins over a step
    always_ff @(posedge clk_i) begin
      if (reset_i || count_clear_i[b]) begin
        mismatch_q <= '0;
        fix_q      <= '0;
        uncorr_q   <= '0;
      end else begin
        if (read_fix_i[b]) begin
          mismatch_q <= mismatch_q + 1'b1;
        end
        if (scrub_fix_i[b]) begin
          fix_q <= fix_q + 1'b1;
        end
        if (scrub_uncorr_i[b]) begin
          uncorr_q <= uncorr_q + 1'b1;
        end
      end
    end

    // Timer runs 0 to interval and then reloads, so the period is interval+1 cycles
    // A lowered interval below the current count also reloads it
    always_ff @(posedge clk_i) begin
      if (reset_i || !interval_on || timer_q >= scrub_interval_i) begin
        timer_q <= '0;
      end else begin
        timer_q <= timer_q + 1'b1;
      end
    end

    assign scrub_trigger_o[b]   = interval_on && (timer_q == scrub_interval_i);
    assign mismatch_count_o[b]  = mismatch_q;
    assign scrub_fix_count_o[b] = fix_q;
    assign uncorr_count_o[b]    = uncorr_q;

    // A trigger only comes from a timer that counted under a live interval
    // It also lasts a single cycle
    trigger_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      scrub_trigger_o[b] |-> $past(interval_on) ##1 !scrub_trigger_o[b]);
  end

endmodule

// ==== hdl/ecc_sram_bank.sv ====
`timescale 1ns/1ps
// One SECDED-protected SRAM bank with write fault injection
// Corrects on read and runs a background scrubber on trigger
module ecc_sram_bank (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  ecc_sram_pkg::word_addr_t addr_i,
  input  ecc_sram_pkg::data_t      wdata_i,
  input  ecc_sram_pkg::data_t      inj_data_mask_i,
  input  ecc_sram_pkg::ecc_t       inj_ecc_mask_i,
  input  logic                     scrub_trigger_i,
  output ecc_sram_pkg::data_t      rdata_o,
  output logic                     rvalid_o,
  output logic                     rerr_o,
  output logic                     read_fix_o,
  output logic                     scrub_fix_o,
  output logic                     scrub_uncorr_o
);

  typedef enum logic [1:0] {ScrubIdle, ScrubRead, ScrubWb} scrub_state_e;

  ecc_sram_pkg::code_t      mem [ecc_sram_pkg::WordsPerBank];
  ecc_sram_pkg::code_t      rd_code_q, scrub_code_q;
  ecc_sram_pkg::data_t      scrub_data;
  ecc_sram_pkg::word_addr_t scrub_addr_q;
  scrub_state_e             scrub_state_q;
  logic                     rd_single, rd_double, scrub_single, scrub_double;
  logic                     pending_q, scrub_read, wb_cancel, wb_done, wb_write;

  // Memory starts as all-zero words, which are valid codewords
  initial begin
    for (int unsigned i = 0; i < ecc_sram_pkg::WordsPerBank; i++) begin
      mem[i] = '0;
    end
  end

  // Scrub read only takes a cycle where the user port is quiet
  assign scrub_read = (scrub_state_q == ScrubRead) && !req_i;
  // A user write to the word under repair makes the write-back stale
  assign wb_cancel  = req_i && we_i && (addr_i == scrub_addr_q);
  assign wb_done    = (scrub_state_q == ScrubWb) && (!req_i || wb_cancel);
  assign wb_write   = (scrub_state_q == ScrubWb) && !req_i && scrub_single;

  // User writes store the codeword with the injection masks flipped in
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[addr_i] <= ecc_sram_pkg::secded_encode(wdata_i) ^ {inj_ecc_mask_i, inj_data_mask_i};
    end else if (wb_write) begin
      mem[scrub_addr_q] <= ecc_sram_pkg::secded_encode(scrub_data);
    end
    if (req_i && !we_i) begin
      rd_code_q <= mem[addr_i];
    end
    if (scrub_read) begin
      scrub_code_q <= mem[scrub_addr_q];
    end
  end

  // User read path, decoded in the cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && !we_i;
    end
  end

  always_comb begin
    rdata_o = ecc_sram_pkg::secded_decode(rd_code_q, rd_single, rd_double);
  end

  // A read reports a fix but leaves the stored word alone
  assign rerr_o     = rvalid_o && rd_double;
  assign read_fix_o = rvalid_o && rd_single;

  always_comb begin
    scrub_data = ecc_sram_pkg::secded_decode(scrub_code_q, scrub_single, scrub_double);
  end

  // Scrub outcome pulses in the cycle the write-back slot is taken
  assign scrub_fix_o    = (scrub_state_q == ScrubWb) && !req_i && scrub_single;
  assign scrub_uncorr_o = (scrub_state_q == ScrubWb) && !req_i && scrub_double;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scrub_state_q <= ScrubIdle;
      scrub_addr_q  <= '0;
      pending_q     <= 1'b0;
    end else begin
      // Triggers arriving while the bank is busy wait in the pending flag
      if (scrub_trigger_i) begin
        pending_q <= 1'b1;
      end else if (scrub_state_q == ScrubIdle && pending_q) begin
        pending_q <= 1'b0;
      end
      unique case (scrub_state_q)
        ScrubIdle: begin
          if (pending_q) begin
            scrub_state_q <= ScrubRead;
          end
        end
        ScrubRead: begin
          if (scrub_read) begin
            scrub_state_q <= ScrubWb;
          end
        end
        default: begin
          // Address wraps from 255 to 0 on its own
          if (wb_done) begin
            scrub_state_q <= ScrubIdle;
            scrub_addr_q  <= scrub_addr_q + 1'b1;
          end
        end
      endcase
    end
  end

  // One scrub outcome per step, never both and never two cycles running
  scrub_outcome: assert property (@(posedge clk_i) disable iff (reset_i)
    (scrub_fix_o || scrub_uncorr_o) |->
      !(scrub_fix_o && scrub_uncorr_o) ##1 !(scrub_fix_o || scrub_uncorr_o));

endmodule

// ==== hdl/ecc_sram_subsys.sv ====
`timescale 1ns/1ps
// Top level of the ECC SRAM subsystem
// AXI4-Lite register file, fault monitor and two protected SRAM banks
module ecc_sram_subsys (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ecc_sram_pkg::axil_addr_t s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  ecc_sram_pkg::data_t      s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  output logic [1:0]               s_axil_bresp_o,
  input  ecc_sram_pkg::axil_addr_t s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output ecc_sram_pkg::data_t      s_axil_rdata_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,
  output logic [1:0]               s_axil_rresp_o,
  input  logic                     mem_req_i,
  input  logic                     mem_we_i,
  input  ecc_sram_pkg::bank_sel_t  mem_bank_i,
  input  ecc_sram_pkg::word_addr_t mem_addr_i,
  input  ecc_sram_pkg::data_t      mem_wdata_i,
  output ecc_sram_pkg::data_t      mem_rdata_o,
  output logic                     mem_rvalid_o,
  output logic                     mem_rerr_o
);

  localparam int unsigned NB = ecc_sram_pkg::NumBanks;

  ecc_sram_pkg::count_t             scrub_interval;
  ecc_sram_pkg::count_t [NB-1:0]    mismatch_count, scrub_fix_count, uncorr_count;
  ecc_sram_pkg::data_t  [NB-1:0]    inj_data_mask, bank_rdata;
  ecc_sram_pkg::ecc_t   [NB-1:0]    inj_ecc_mask;
  logic                 [NB-1:0]    count_clear, scrub_trigger, bank_req;
  logic                 [NB-1:0]    read_fix, scrub_fix, scrub_uncorr, bank_rvalid, bank_rerr;
  ecc_sram_pkg::bank_sel_t          rd_bank_q;

  ecc_axil_regs i_regs (
    .clk_i,
    .reset_i,
    .s_axil_awaddr_i,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_wdata_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_bresp_o,
    .s_axil_araddr_i,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_rdata_o,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .s_axil_rresp_o,
    .scrub_interval_o  ( scrub_interval  ),
    .count_clear_o     ( count_clear     ),
    .inj_data_mask_o   ( inj_data_mask   ),
    .inj_ecc_mask_o    ( inj_ecc_mask    ),
    .mismatch_count_i  ( mismatch_count  ),
    .scrub_fix_count_i ( scrub_fix_count ),
    .uncorr_count_i    ( uncorr_count    )
  );

  ecc_fault_monitor i_monitor (
    .clk_i,
    .reset_i,
    .scrub_interval_i  ( scrub_interval  ),
    .count_clear_i     ( count_clear     ),
    .read_fix_i        ( read_fix        ),
    .scrub_fix_i       ( scrub_fix       ),
    .scrub_uncorr_i    ( scrub_uncorr    ),
    .mismatch_count_o  ( mismatch_count  ),
    .scrub_fix_count_o ( scrub_fix_count ),
    .uncorr_count_o    ( uncorr_count    ),
    .scrub_trigger_o   ( scrub_trigger   )
  );

  for (genvar b = 0; b < NB; b++) begin : gen_bank
    // Only the addressed bank sees the request
    assign bank_req[b] = mem_req_i && (mem_bank_i == ecc_sram_pkg::bank_sel_t'(b));

    ecc_sram_bank i_bank (
      .clk_i,
      .reset_i,
      .req_i           ( bank_req[b]      ),
      .we_i            ( mem_we_i         ),
      .addr_i          ( mem_addr_i       ),
      .wdata_i         ( mem_wdata_i      ),
      .inj_data_mask_i ( inj_data_mask[b] ),
      .inj_ecc_mask_i  ( inj_ecc_mask[b]  ),
      .scrub_trigger_i ( scrub_trigger[b] ),
      .rdata_o         ( bank_rdata[b]    ),
      .rvalid_o        ( bank_rvalid[b]   ),
      .rerr_o          ( bank_rerr[b]     ),
      .read_fix_o      ( read_fix[b]      ),
      .scrub_fix_o     ( scrub_fix[b]     ),
      .scrub_uncorr_o  ( scrub_uncorr[b]  )
    );
  end

  // Remember which bank was read so its response is returned next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_bank_q <= '0;
    end else if (mem_req_i && !mem_we_i) begin
      rd_bank_q <= mem_bank_i;
    end
  end

  assign mem_rvalid_o = |bank_rvalid;
  assign mem_rdata_o  = bank_rdata[rd_bank_q];
  assign mem_rerr_o   = bank_rerr[rd_bank_q];

endmodule

// ==== test/tb_ecc_sram_subsys.sv ====
`timescale 1ns/1ps
// Testbench of the ECC SRAM subsystem
// Replays the operation lines of the vector file against the DUT
// AXI4-Lite and memory port drivers, random write/read pairs and a watchdog
module tb_ecc_sram_subsys;

  localparam VecFile = "test/ecc_sram_vectors.txt";
  // Cycles an AXI channel may take before the handshake counts as lost
  localparam int unsigned AxiTimeout = 16;

  logic                     clk, reset;
  ecc_sram_pkg::axil_addr_t awaddr, araddr;
  ecc_sram_pkg::data_t      wdata, rdata, mem_wdata, mem_rdata;
  logic                     awvalid, awready, wvalid, wready, bvalid, bready;
  logic                     arvalid, arready, rvalid, rready;
  logic [1:0]               bresp, rresp;
  logic                     mem_req, mem_we, mem_rvalid, mem_rerr;
  ecc_sram_pkg::bank_sel_t  mem_bank;
  ecc_sram_pkg::word_addr_t mem_addr;
  int unsigned              errors, checks, vec_no;
  logic [31:0]              rng_state;

  ecc_sram_subsys uut (
    .clk_i            ( clk        ),
    .reset_i          ( reset      ),
    .s_axil_awaddr_i  ( awaddr     ),
    .s_axil_awvalid_i ( awvalid    ),
    .s_axil_awready_o ( awready    ),
    .s_axil_wdata_i   ( wdata      ),
    .s_axil_wvalid_i  ( wvalid     ),
    .s_axil_wready_o  ( wready     ),
    .s_axil_bvalid_o  ( bvalid     ),
    .s_axil_bready_i  ( bready     ),
    .s_axil_bresp_o   ( bresp      ),
    .s_axil_araddr_i  ( araddr     ),
    .s_axil_arvalid_i ( arvalid    ),
    .s_axil_arready_o ( arready    ),
    .s_axil_rdata_o   ( rdata      ),
    .s_axil_rvalid_o  ( rvalid     ),
    .s_axil_rready_i  ( rready     ),
    .s_axil_rresp_o   ( rresp      ),
    .mem_req_i        ( mem_req    ),
    .mem_we_i         ( mem_we     ),
    .mem_bank_i       ( mem_bank   ),
    .mem_addr_i       ( mem_addr   ),
    .mem_wdata_i      ( mem_wdata  ),
    .mem_rdata_o      ( mem_rdata  ),
    .mem_rvalid_o     ( mem_rvalid ),
    .mem_rerr_o       ( mem_rerr   )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // 32-bit xorshift generator for the random write/read pairs
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Every task starts and ends 1 ns after a rising edge
  // Outputs are sampled 2 ns after the edge when all of them have settled
  task automatic axi_write(input ecc_sram_pkg::axil_addr_t addr, input ecc_sram_pkg::data_t data);
    logic        aw_fire, w_fire, b_seen;
    int unsigned n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n       = 0;
    // AW and W may be taken in different cycles
    while ((awvalid || wvalid) && n < AxiTimeout) begin
      #1;
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_fire) begin
        awvalid = 1'b0;
      end
      if (w_fire) begin
        wvalid = 1'b0;
      end
      n++;
    end
    if (awvalid || wvalid) begin
      errors++;
      $display("AXI write to %h was not accepted (vector %0d)", addr, vec_no);
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end
    b_seen = 1'b0;
    n      = 0;
    while (!b_seen && n < AxiTimeout) begin
      #1;
      b_seen = bvalid;
      checks++;
      if (b_seen && bresp !== 2'b00) begin
        errors++;
        $display("FAILED s_axil_bresp_o (vector %0d): expected 0, got %h", vec_no, bresp);
      end
      @(posedge clk);
      #1;
      n++;
    end
    if (!b_seen) begin
      errors++;
      $display("No write response came for address %h (vector %0d)", addr, vec_no);
    end
  endtask

  task automatic axi_read_check(input ecc_sram_pkg::axil_addr_t addr,
                                input ecc_sram_pkg::data_t exp);
    logic                ar_fire, r_seen;
    ecc_sram_pkg::data_t got;
    logic [1:0]          got_resp;
    int unsigned         n;
    araddr  = addr;
    arvalid = 1'b1;
    ar_fire = 1'b0;
    r_seen  = 1'b0;
    n       = 0;
    while (!ar_fire && n < AxiTimeout) begin
      #1;
      ar_fire = arready;
      @(posedge clk);
      #1;
      n++;
    end
    arvalid = 1'b0;
    n       = 0;
    while (ar_fire && !r_seen && n < AxiTimeout) begin
      #1;
      r_seen   = rvalid;
      got      = rdata;
      got_resp = rresp;
      @(posedge clk);
      #1;
      n++;
    end
    checks++;
    if (!r_seen) begin
      errors++;
      $display("No read response came for address %h (vector %0d)", addr, vec_no);
    end else begin
      if (got !== exp) begin
        errors++;
        $display("FAILED s_axil_rdata_o at %h (vector %0d): expected %h, got %h",
                 addr, vec_no, exp, got);
      end
      if (got_resp !== 2'b00) begin
        errors++;
        $display("FAILED s_axil_rresp_o at %h (vector %0d): expected 0, got %h",
                 addr, vec_no, got_resp);
      end
    end
  endtask

  task automatic mem_write(input ecc_sram_pkg::bank_sel_t bank,
                           input ecc_sram_pkg::word_addr_t addr, input ecc_sram_pkg::data_t data);
    mem_req   = 1'b1;
    mem_we    = 1'b1;
    mem_bank  = bank;
    mem_addr  = addr;
    mem_wdata = data;
    @(posedge clk);
    #1;
    mem_req = 1'b0;
    mem_we  = 1'b0;
  endtask

  // The response is due exactly one cycle after the read is taken
  task automatic mem_read_check(input ecc_sram_pkg::bank_sel_t bank,
                                input ecc_sram_pkg::word_addr_t addr,
                                input ecc_sram_pkg::data_t exp_data, input logic exp_err);
    mem_req  = 1'b1;
    mem_we   = 1'b0;
    mem_bank = bank;
    mem_addr = addr;
    @(posedge clk);
    #1;
    mem_req = 1'b0;
    #1;
    checks++;
    if (mem_rvalid !== 1'b1) begin
      errors++;
      $display("No read data one cycle after reading bank %0d address %h (vector %0d)",
               bank, addr, vec_no);
    end else begin
      if (mem_rdata !== exp_data) begin
        errors++;
        $display("FAILED mem_rdata_o at %0d:%h (vector %0d): expected %h, got %h",
                 bank, addr, vec_no, exp_data, mem_rdata);
      end
      if (mem_rerr !== exp_err) begin
        errors++;
        $display("FAILED mem_rerr_o at %0d:%h (vector %0d): expected %h, got %h",
                 bank, addr, vec_no, exp_err, mem_rerr);
      end
    end
    @(posedge clk);
    #1;
  endtask

  // Masks are clear here so every read must return the written data without error
  task automatic random_pairs(input int unsigned count);
    ecc_sram_pkg::bank_sel_t  bank;
    ecc_sram_pkg::word_addr_t addr;
    ecc_sram_pkg::data_t      data;
    for (int unsigned i = 0; i < count; i++) begin
      rng_state = xorshift32(rng_state);
      bank      = ecc_sram_pkg::bank_sel_t'(rng_state[0]);
      addr      = rng_state[15:8];
      rng_state = xorshift32(rng_state);
      data      = rng_state;
      mem_write(bank, addr, data);
      mem_read_check(bank, addr, data, 1'b0);
    end
  endtask

  task automatic run_op(input logic [63:0] op, input logic [31:0] f0, input logic [31:0] f1,
                        input logic [31:0] f2, input logic [31:0] f3);
    case (op)
      "AW": axi_write(f0[7:0], f1);
      "AR": axi_read_check(f0[7:0], f1);
      "MW": mem_write(ecc_sram_pkg::bank_sel_t'(f0), f1[7:0], f2);
      "MR": mem_read_check(ecc_sram_pkg::bank_sel_t'(f0), f1[7:0], f2, f3[0]);
      "WT": begin
        repeat (f0) @(posedge clk);
        #1;
      end
      "RND": random_pairs(f0);
      default: begin
        errors++;
        $display("Vector %0d has an unknown opcode", vec_no);
      end
    endcase
  endtask

  initial begin : replay
    int               fd, code;
    logic [63:0]      op;
    logic [8*256-1:0] rest;
    logic [31:0]      f0, f1, f2, f3;
    errors    = 0;
    checks    = 0;
    vec_no    = 0;
    rng_state = 32'd15658;
    reset     = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    mem_req   = 1'b0;
    mem_we    = 1'b0;
    mem_bank  = '0;
    mem_addr  = '0;
    mem_wdata = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    fd = $fopen(VecFile, "r");
    if (fd == 0) begin
      errors++;
      $display("The vector file %s could not be opened", VecFile);
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", op);
        if (code == 1) begin
          // A lone # token starts a comment that runs to the end of the line
          if (op == "#") begin
            code = $fgets(rest, fd);
          end else begin
            vec_no++;
            code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            if (code != 4) begin
              errors++;
              $display("Vector %0d does not have four hex fields", vec_no);
            end else begin
              run_op(op, f0, f1, f2, f3);
            end
          end
        end
      end
      $fclose(fd);
    end
    repeat (4) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget of 20 cycles per vector line plus a fixed margin
  initial begin : watchdog
    int               fd;
    int unsigned      lines;
    logic [8*256-1:0] line_buf;
    lines = 0;
    fd    = $fopen(VecFile, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line_buf, fd) != 0) begin
          lines++;
        end
      end
      $fclose(fd);
    end
    repeat (20 * lines + 2000) @(posedge clk);
    $display("Timeout after %0d cycles, the replay did not finish", 20 * lines + 2000);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== test/ecc_sram_vectors.txt ====
# Columns: opcode and four hex fields, unused fields are 0
# AW addr data | AR addr expect | MW bank addr data | MR bank addr data rerr | WT cycles | RND pairs
RND 28 0 0 0
AR 10 0 0 0
AR 14 0 0 0
AW 44 00010000 0 0
MW 1 85 deadbeef 0
AW 44 0 0 0
MR 1 85 deadbeef 0
AW 54 00000040 0 0
MW 1 86 12345678 0
AW 54 0 0 0
MR 1 86 12345678 0
MR 1 86 12345678 0
AR 14 3 0 0
AW 44 00000001 0 0
AW 54 00000002 0 0
MW 1 87 cafef00d 0
AW 44 0 0 0
AW 54 0 0 0
MR 1 87 cafef00c 1
AR 14 3 0 0
AW 24 0 0 0
AR 14 0 0 0
AR 24 0 0 0
AR 34 0 0 0
AW 40 00000100 0 0
AR 40 00000100 0 0
MW 0 00 a5a5a5a5 0
AW 40 00000003 0 0
MW 0 01 0f0f0f0f 0
AW 40 0 0 0
AR 30 0 0 0
AW 00 3 0 0
AR 00 3 0 0
WT 0c 0 0 0
AR 20 1 0 0
WT 4 0 0 0
AR 30 1 0 0
AW 00 0 0 0
MR 0 00 a5a5a5a5 0
AR 10 0 0 0
MR 0 01 0f0f0f0c 1
AW 30 0 0 0
AR 20 0 0 0
AR 30 0 0 0
AW 50 ffffffff 0 0
AR 50 7f 0 0
AW 50 0 0 0
AR 08 0 0 0
AR 48 0 0 0
AR 60 0 0 0

// ==== ecc_sram_subsys.f ====
hdl/ecc_sram_pkg.sv
hdl/ecc_axil_regs.sv
hdl/ecc_fault_monitor.sv
hdl/ecc_sram_bank.sv
hdl/ecc_sram_subsys.sv
test/tb_ecc_sram_subsys.sv

// ==== Bender.yml ====
package:
  name: ecc_sram_subsys

sources:
  - hdl/ecc_sram_pkg.sv
  - hdl/ecc_axil_regs.sv
  - hdl/ecc_fault_monitor.sv
  - hdl/ecc_sram_bank.sv
  - hdl/ecc_sram_subsys.sv
  - target: test
    files:
      - test/tb_ecc_sram_subsys.sv
